// ==== verilog/rv_pkg.sv ====
package rv_pkg;

  // data and address width
  parameter int XLEN       = 32;
  parameter int REG_ADDR_W = 5;

  // major opcodes kept in this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // writeback source
  typedef enum logic [1:0] {
    WB_LOAD = 2'b00,
    WB_ALU  = 2'b01,
    WB_PC4  = 2'b10
  } wb_sel_e;

  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_MEM  = 2'b01,
    FWD_WB   = 2'b10
  } fwd_sel_e;

  typedef enum logic {
    OPA_RS1 = 1'b0,
    OPA_PC  = 1'b1
  } opa_sel_e;

endpackage

// ==== verilog/id_ex_if.sv ====
`timescale 1ns/1ns

// decoded instruction held in the ID/EX register
interface id_ex_if import rv_pkg::*; ();
  logic                  valid;
  logic [XLEN-1:0]       pc;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       imm;
  alu_op_e               alu_op;
  opa_sel_e              opa_sel;
  logic                  use_imm;
  logic                  rd_wren;
  logic                  mem_wren;
  logic                  mem_rden;
  wb_sel_e               wb_sel;
  logic                  is_branch;
  logic [2:0]            funct3;
  logic                  is_jal;
  logic                  is_jalr;

  modport source (
    output valid, pc, rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, imm,
           alu_op, opa_sel, use_imm, rd_wren, mem_wren, mem_rden, wb_sel,
           is_branch, funct3, is_jal, is_jalr
  );

  modport sink (
    input valid, pc, rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, imm,
          alu_op, opa_sel, use_imm, rd_wren, mem_wren, mem_rden, wb_sel,
          is_branch, funct3, is_jal, is_jalr
  );

  // hazard detection only looks at these
  modport monitor (
    input valid, rs1_addr, rs2_addr, rd_addr, mem_rden
  );
endinterface

// ==== verilog/regfile.sv ====
`timescale 1ns/1ns

module regfile import rv_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [REG_ADDR_W-1:0] i_rs1_addr,
  input  logic [REG_ADDR_W-1:0] i_rs2_addr,
  input  logic                  i_wren,
  input  logic [REG_ADDR_W-1:0] i_rd_addr,
  input  logic [XLEN-1:0]       i_rd_data,
  output logic [XLEN-1:0]       o_rs1_data,
  output logic [XLEN-1:0]       o_rs2_data
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wren && i_rd_addr != '0) begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // same-cycle write is seen by the reader
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                      (i_wren && i_rd_addr == i_rs1_addr) ? i_rd_data : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                      (i_wren && i_rd_addr == i_rs2_addr) ? i_rd_data : regs[i_rs2_addr];

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_stall,
  input  logic            i_flush,
  input  logic            i_redirect,
  input  logic [XLEN-1:0] i_target,
  input  logic [XLEN-1:0] i_instr,
  output logic [XLEN-1:0] o_pc,
  output logic            o_id_valid,
  output logic [XLEN-1:0] o_id_pc,
  output logic [XLEN-1:0] o_id_instr
);

  logic [XLEN-1:0] pc;

  // redirect wins over the load-use hold
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc <= RESET_PC;
    end else if (i_redirect) begin
      pc <= i_target;
    end else if (!i_stall) begin
      pc <= pc + XLEN'(4);
    end
  end

  // IF/ID valid bit
  always_ff @(posedge i_clk) begin
    if (i_rst || i_flush) begin
      o_id_valid <= 1'b0;
    end else if (!i_stall) begin
      o_id_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_id_pc    <= pc;
      o_id_instr <= i_instr;
    end
  end

  assign o_pc = pc;

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage import rv_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_valid,
  input  logic [XLEN-1:0]       i_pc,
  input  logic [XLEN-1:0]       i_instr,
  input  logic                  i_bubble,
  input  logic                  i_wb_wren,
  input  logic [REG_ADDR_W-1:0] i_wb_rd,
  input  logic [XLEN-1:0]       i_wb_data,
  id_ex_if.source               ex
);

  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] imm;
  logic [2:0]      funct3;
  logic            known;
  alu_op_e         alu_op;
  opa_sel_e        opa_sel;
  wb_sel_e         wb_sel;
  logic            use_imm;
  logic            rd_wren;
  logic            mem_wren;
  logic            mem_rden;
  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;

  // funct7 bit 30 picks sub only for register ops, sra for both
  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic b30,
                                             input logic reg_op);
    case (f3)
      3'b000:  return (reg_op && b30) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return b30 ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign funct3 = i_instr[14:12];

  always_comb begin
    known     = 1'b1;
    alu_op    = ALU_ADD;
    opa_sel   = OPA_RS1;
    use_imm   = 1'b1;
    wb_sel    = WB_ALU;
    rd_wren   = 1'b1;
    mem_wren  = 1'b0;
    mem_rden  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    // I-type by default
    imm       = {{20{i_instr[31]}}, i_instr[31:20]};
    case (opcode_e'(i_instr[6:0]))
      OPC_OP: begin
        use_imm = 1'b0;
        alu_op  = alu_from_funct(funct3, i_instr[30], 1'b1);
      end
      OPC_OP_IMM: alu_op = alu_from_funct(funct3, i_instr[30], 1'b0);
      OPC_LUI: begin
        alu_op = ALU_PASS_B;
        imm    = {i_instr[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        opa_sel = OPA_PC;
        imm     = {i_instr[31:12], 12'b0};
      end
      OPC_LOAD: begin
        mem_rden = 1'b1;
        wb_sel   = WB_LOAD;
      end
      OPC_STORE: begin
        rd_wren  = 1'b0;
        mem_wren = 1'b1;
        imm      = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
      end
      OPC_BRANCH: begin
        rd_wren   = 1'b0;
        is_branch = 1'b1;
        imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
      end
      OPC_JAL: begin
        is_jal = 1'b1;
        wb_sel = WB_PC4;
        imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20], i_instr[30:21],
               1'b0};
      end
      OPC_JALR: begin
        is_jalr = 1'b1;
        wb_sel  = WB_PC4;
      end
      default: known = 1'b0;
    endcase
  end

  regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1_addr (i_instr[19:15]),
    .i_rs2_addr (i_instr[24:20]),
    .i_wren     (i_wb_wren),
    .i_rd_addr  (i_wb_rd),
    .i_rd_data  (i_wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // ID/EX control, an unknown opcode leaves a bubble
  always_ff @(posedge i_clk) begin
    if (i_rst || i_bubble || !(i_valid && known)) begin
      ex.valid     <= 1'b0;
      ex.rd_wren   <= 1'b0;
      ex.mem_wren  <= 1'b0;
      ex.mem_rden  <= 1'b0;
      ex.is_branch <= 1'b0;
      ex.is_jal    <= 1'b0;
      ex.is_jalr   <= 1'b0;
    end else begin
      ex.valid     <= 1'b1;
      ex.rd_wren   <= rd_wren;
      ex.mem_wren  <= mem_wren;
      ex.mem_rden  <= mem_rden;
      ex.is_branch <= is_branch;
      ex.is_jal    <= is_jal;
      ex.is_jalr   <= is_jalr;
    end
  end

  // ID/EX payload
  always_ff @(posedge i_clk) begin
    ex.pc       <= i_pc;
    ex.rs1_addr <= i_instr[19:15];
    ex.rs2_addr <= i_instr[24:20];
    ex.rd_addr  <= i_instr[11:7];
    ex.rs1_data <= rs1_data;
    ex.rs2_data <= rs2_data;
    ex.imm      <= imm;
    ex.alu_op   <= alu_op;
    ex.opa_sel  <= opa_sel;
    ex.use_imm  <= use_imm;
    ex.wb_sel   <= wb_sel;
    ex.funct3   <= funct3;
  end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage import rv_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  fwd_sel_e              i_fwd_a,
  input  fwd_sel_e              i_fwd_b,
  input  logic [XLEN-1:0]       i_dmem_rdata,
  id_ex_if.sink                 ex,
  output logic                  o_redirect,
  output logic [XLEN-1:0]       o_target,
  output logic [XLEN-1:0]       o_dmem_addr,
  output logic [XLEN-1:0]       o_dmem_wdata,
  output logic                  o_dmem_we,
  output logic                  o_mem_rd_wren,
  output logic [REG_ADDR_W-1:0] o_mem_rd,
  output logic                  o_mem_is_load,
  output logic                  o_wb_wren,
  output logic [REG_ADDR_W-1:0] o_wb_rd,
  output logic [XLEN-1:0]       o_wb_data
);

  logic [XLEN-1:0] rs1_v;
  logic [XLEN-1:0] rs2_v;
  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] tgt_sum;
  logic            br_taken;
  logic [XLEN-1:0] mem_result;
  wb_sel_e         mem_wb_sel;
  logic [XLEN-1:0] wb_result;
  logic [XLEN-1:0] wb_ldata;
  wb_sel_e         wb_sel;

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel, input logic [XLEN-1:0] reg_v,
                                              input logic [XLEN-1:0] mem_v,
                                              input logic [XLEN-1:0] wb_v);
    case (sel)
      FWD_MEM: return mem_v;
      FWD_WB:  return wb_v;
      default: return reg_v;
    endcase
  endfunction

  assign rs1_v = fwd_mux(i_fwd_a, ex.rs1_data, mem_result, o_wb_data);
  assign rs2_v = fwd_mux(i_fwd_b, ex.rs2_data, mem_result, o_wb_data);
  assign opa   = (ex.opa_sel == OPA_PC) ? ex.pc : rs1_v;
  assign opb   = ex.use_imm ? ex.imm : rs2_v;

  always_comb begin
    case (ex.alu_op)
      ALU_SUB:    alu_res = opa - opb;
      ALU_SLL:    alu_res = opa << opb[4:0];
      ALU_SLT:    alu_res = XLEN'($signed(opa) < $signed(opb));
      ALU_SLTU:   alu_res = XLEN'(opa < opb);
      ALU_XOR:    alu_res = opa ^ opb;
      ALU_SRL:    alu_res = opa >> opb[4:0];
      ALU_SRA:    alu_res = $unsigned($signed(opa) >>> opb[4:0]);
      ALU_OR:     alu_res = opa | opb;
      ALU_AND:    alu_res = opa & opb;
      ALU_PASS_B: alu_res = opb;
      default:    alu_res = opa + opb;
    endcase
  end

  // branch condition from funct3
  always_comb begin
    case (ex.funct3)
      3'b000:  br_taken = (rs1_v == rs2_v);
      3'b001:  br_taken = (rs1_v != rs2_v);
      3'b100:  br_taken = ($signed(rs1_v) < $signed(rs2_v));
      3'b101:  br_taken = ($signed(rs1_v) >= $signed(rs2_v));
      3'b110:  br_taken = (rs1_v < rs2_v);
      3'b111:  br_taken = (rs1_v >= rs2_v);
      default: br_taken = 1'b0;
    endcase
  end

  // jalr clears bit 0, branch and jal targets are even anyway
  assign tgt_sum    = (ex.is_jalr ? rs1_v : ex.pc) + ex.imm;
  assign o_target   = {tgt_sum[XLEN-1:1], 1'b0};
  assign o_redirect = ex.valid && (ex.is_jal || ex.is_jalr || (ex.is_branch && br_taken));

  // EX/MEM
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_dmem_we     <= 1'b0;
      o_mem_rd_wren <= 1'b0;
      o_mem_is_load <= 1'b0;
    end else begin
      o_dmem_we     <= ex.mem_wren;
      o_mem_rd_wren <= ex.rd_wren;
      o_mem_is_load <= ex.mem_rden;
    end
  end

  always_ff @(posedge i_clk) begin
    mem_result   <= (ex.wb_sel == WB_PC4) ? ex.pc + XLEN'(4) : alu_res;
    o_dmem_wdata <= rs2_v;
    o_mem_rd     <= ex.rd_addr;
    mem_wb_sel   <= ex.wb_sel;
  end

  assign o_dmem_addr = mem_result;

  // MEM/WB
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb_wren <= 1'b0;
    end else begin
      o_wb_wren <= o_mem_rd_wren;
    end
  end

  always_ff @(posedge i_clk) begin
    wb_result <= mem_result;
    wb_ldata  <= i_dmem_rdata;
    o_wb_rd   <= o_mem_rd;
    wb_sel    <= mem_wb_sel;
  end

  assign o_wb_data = (wb_sel == WB_LOAD) ? wb_ldata : wb_result;

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit import rv_pkg::*; (
  id_ex_if.monitor              ex,
  input  logic [XLEN-1:0]       i_id_instr,
  input  logic                  i_id_valid,
  input  logic                  i_redirect,
  input  logic                  i_mem_rd_wren,
  input  logic [REG_ADDR_W-1:0] i_mem_rd,
  input  logic                  i_mem_is_load,
  input  logic                  i_wb_wren,
  input  logic [REG_ADDR_W-1:0] i_wb_rd,
  output logic                  o_stall,
  output logic                  o_flush,
  output logic                  o_bubble,
  output fwd_sel_e              o_fwd_a,
  output fwd_sel_e              o_fwd_b
);

  opcode_e id_opc;
  logic    uses_rs1;
  logic    uses_rs2;
  logic    load_use;

  // memory stage wins, x0 never forwarded
  function automatic fwd_sel_e pick_fwd(input logic [REG_ADDR_W-1:0] rs);
    if (i_mem_rd_wren && !i_mem_is_load && i_mem_rd != '0 && i_mem_rd == rs) begin
      return FWD_MEM;
    end else if (i_wb_wren && i_wb_rd != '0 && i_wb_rd == rs) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  assign id_opc   = opcode_e'(i_id_instr[6:0]);
  assign uses_rs1 = !(id_opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL});
  assign uses_rs2 = id_opc inside {OPC_OP, OPC_STORE, OPC_BRANCH};

  // load in execute feeding the instruction in decode
  assign load_use = i_id_valid && ex.valid && ex.mem_rden && ex.rd_addr != '0 &&
                    ((uses_rs1 && ex.rd_addr == i_id_instr[19:15]) ||
                     (uses_rs2 && ex.rd_addr == i_id_instr[24:20]));

  assign o_stall  = load_use;
  assign o_flush  = i_redirect;
  assign o_bubble = load_use || i_redirect;
  assign o_fwd_a  = pick_fwd(ex.rs1_addr);
  assign o_fwd_b  = pick_fwd(ex.rs2_addr);

endmodule

// ==== verilog/pipelined.sv ====
`timescale 1ns/1ns

module pipelined import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            i_clk,
  input  logic            i_rst,
  output logic [XLEN-1:0] o_imem_addr,
  input  logic [XLEN-1:0] i_imem_data,
  output logic [XLEN-1:0] o_dmem_addr,
  output logic [XLEN-1:0] o_dmem_wdata,
  output logic            o_dmem_we,
  input  logic [XLEN-1:0] i_dmem_rdata
);

  logic                  id_valid;
  logic [XLEN-1:0]       id_pc;
  logic [XLEN-1:0]       id_instr;
  logic                  stall;
  logic                  flush;
  logic                  bubble;
  logic                  redirect;
  logic [XLEN-1:0]       target;
  fwd_sel_e              fwd_a;
  fwd_sel_e              fwd_b;
  logic                  mem_rd_wren;
  logic [REG_ADDR_W-1:0] mem_rd;
  logic                  mem_is_load;
  logic                  wb_wren;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;

  id_ex_if id_ex ();

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_stall    (stall),
    .i_flush    (flush),
    .i_redirect (redirect),
    .i_target   (target),
    .i_instr    (i_imem_data),
    .o_pc       (o_imem_addr),
    .o_id_valid (id_valid),
    .o_id_pc    (id_pc),
    .o_id_instr (id_instr)
  );

  decode_stage u_decode (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_valid   (id_valid),
    .i_pc      (id_pc),
    .i_instr   (id_instr),
    .i_bubble  (bubble),
    .i_wb_wren (wb_wren),
    .i_wb_rd   (wb_rd),
    .i_wb_data (wb_data),
    .ex        (id_ex.source)
  );

  execute_stage u_execute (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_fwd_a       (fwd_a),
    .i_fwd_b       (fwd_b),
    .i_dmem_rdata  (i_dmem_rdata),
    .ex            (id_ex.sink),
    .o_redirect    (redirect),
    .o_target      (target),
    .o_dmem_addr   (o_dmem_addr),
    .o_dmem_wdata  (o_dmem_wdata),
    .o_dmem_we     (o_dmem_we),
    .o_mem_rd_wren (mem_rd_wren),
    .o_mem_rd      (mem_rd),
    .o_mem_is_load (mem_is_load),
    .o_wb_wren     (wb_wren),
    .o_wb_rd       (wb_rd),
    .o_wb_data     (wb_data)
  );

  hazard_unit u_hazard (
    .ex            (id_ex.monitor),
    .i_id_instr    (id_instr),
    .i_id_valid    (id_valid),
    .i_redirect    (redirect),
    .i_mem_rd_wren (mem_rd_wren),
    .i_mem_rd      (mem_rd),
    .i_mem_is_load (mem_is_load),
    .i_wb_wren     (wb_wren),
    .i_wb_rd       (wb_rd),
    .o_stall       (stall),
    .o_flush       (flush),
    .o_bubble      (bubble),
    .o_fwd_a       (fwd_a),
    .o_fwd_b       (fwd_b)
  );

endmodule

// ==== testbench/pipelined_chk.sv ====
`timescale 1ns/1ns

module pipelined_chk #(
  parameter logic [31:0] RESET_PC = '0
) (
  input logic        i_clk,
  input logic        i_rst,
  input logic [31:0] o_imem_addr,
  input logic        o_dmem_we
);

  a_we_known: assert property (@(posedge i_clk) disable iff (i_rst) !$isunknown(o_dmem_we))
    else $error("o_dmem_we is unknown");

  a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    o_imem_addr[1:0] == 2'b00)
    else $error("o_imem_addr is not word aligned");

  // first fetch after reset comes from the reset vector
  a_reset_pc: assert property (@(posedge i_clk) $fell(i_rst) |-> o_imem_addr == RESET_PC)
    else $error("o_imem_addr differs from the reset vector after reset");

endmodule

bind pipelined pipelined_chk #(
  .RESET_PC (RESET_PC)
) u_chk (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .o_imem_addr (o_imem_addr),
  .o_dmem_we   (o_dmem_we)
);

// ==== testbench/tb_pipelined.sv ====
`timescale 1ns/1ns

module tb_pipelined;

  localparam int N_ROWS     = 5;
  localparam int MAX_WORDS  = 40;
  localparam int MAX_STORES = 16;
  localparam int TIMEOUT    = 200;
  localparam int OPC_OPI    = 7'h13;
  localparam int OPC_LUI    = 7'h37;
  localparam int OPC_AUIPC  = 7'h17;
  localparam int OPC_LOAD   = 7'h03;
  localparam int OPC_JALR   = 7'h67;
  localparam logic [31:0] SEED = 32'hd56d;

  logic        i_clk;
  logic        i_rst;
  logic [31:0] o_imem_addr;
  logic [31:0] i_imem_data;
  logic [31:0] o_dmem_addr;
  logic [31:0] o_dmem_wdata;
  logic        o_dmem_we;
  logic [31:0] i_dmem_rdata;

  logic [31:0] imem [64];
  logic [31:0] dmem [16];

  // program table, one row per test program
  logic [31:0] prog [N_ROWS][MAX_WORDS];
  int          n_words [N_ROWS];
  logic [31:0] exp_addr [N_ROWS][MAX_STORES];
  logic [31:0] exp_val [N_ROWS][MAX_STORES];
  int          n_stores [N_ROWS];
  int          cur_row;

  pipelined #(
    .RESET_PC (32'h0)
  ) dut (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .o_imem_addr  (o_imem_addr),
    .i_imem_data  (i_imem_data),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .i_dmem_rdata (i_dmem_rdata)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // zero-wait memories, updated just after the edge
  always @(posedge i_clk) begin
    #1;
    i_imem_data = imem[o_imem_addr[7:2]];
    i_dmem_rdata = dmem[o_dmem_addr[5:2]];
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand_word(input int idx);
    logic [31:0] st;
    st = SEED;
    for (int k = 0; k <= idx; k++) begin
      st = xorshift32(st);
    end
    return st;
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                        input int rd, input int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input int imm, input int rs1, input int rs2,
                                        input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input int imm20, input int rd, input int opc);
    return {imm20[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] enc_j(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[cur_row][n_words[cur_row]] = w;
    n_words[cur_row]++;
  endtask

  // sw rd to the next result slot and record what must arrive there
  task automatic store_reg(input int rd, input logic [31:0] val);
    int n;
    n = n_stores[cur_row];
    emit(enc_s(256 + 4 * n, rd, 0));
    exp_addr[cur_row][n] = 32'h100 + 32'(4 * n);
    exp_val[cur_row][n]  = val;
    n_stores[cur_row]++;
  endtask

  // sw that a taken jump or branch must skip
  task automatic emit_skipped();
    emit(enc_s(12'h1fc, 1, 0));
  endtask

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] time=%0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic build_table();
    int f3s [6] = '{0, 1, 4, 5, 6, 7};
    int t_a [6] = '{1, 1, 1, 2, 2, 1};
    int t_b [6] = '{1, 2, 2, 1, 1, 2};
    int n_a [6] = '{1, 1, 2, 1, 1, 2};
    int n_b [6] = '{2, 1, 1, 2, 2, 1};
    for (int r = 0; r < N_ROWS; r++) begin
      n_words[r]  = 0;
      n_stores[r] = 0;
    end
    // ALU results, x1 = -12 and x2 = 5
    cur_row = 0;
    emit(enc_i(-12, 0, 0, 1, OPC_OPI));
    emit(enc_i(5, 0, 0, 2, OPC_OPI));
    emit(enc_r(0, 2, 1, 0, 3));
    emit(enc_r(32, 1, 2, 0, 4));
    emit(enc_r(0, 2, 1, 7, 5));
    emit(enc_r(0, 2, 1, 6, 6));
    emit(enc_r(0, 2, 1, 4, 7));
    emit(enc_r(0, 2, 1, 2, 8));
    emit(enc_r(0, 2, 1, 3, 9));
    emit(enc_r(0, 2, 2, 1, 10));
    emit(enc_r(0, 2, 1, 5, 11));
    emit(enc_r(32, 2, 1, 5, 12));
    emit(enc_u(32'h12345, 13, OPC_LUI));
    emit(enc_u(1, 14, OPC_AUIPC));
    emit(enc_i(15, 1, 4, 15, OPC_OPI));
    emit(enc_i(32'h402, 1, 5, 16, OPC_OPI));
    emit(enc_i(-11, 1, 2, 17, OPC_OPI));
    store_reg(3, 32'hffff_fff9);
    store_reg(4, 32'h0000_0011);
    store_reg(5, 32'h0000_0004);
    store_reg(6, 32'hffff_fff5);
    store_reg(7, 32'hffff_fff1);
    store_reg(8, 32'h0000_0001);
    store_reg(9, 32'h0000_0000);
    store_reg(10, 32'h0000_00a0);
    store_reg(11, 32'h07ff_ffff);
    store_reg(12, 32'hffff_ffff);
    store_reg(13, 32'h1234_5000);
    // auipc sits at 0x34
    store_reg(14, 32'h0000_1034);
    store_reg(15, 32'hffff_fffb);
    store_reg(16, 32'hffff_fffd);
    store_reg(17, 32'h0000_0001);
    emit(enc_j(0, 0));
    // dependent add chain
    cur_row = 1;
    emit(enc_i(1, 0, 0, 1, OPC_OPI));
    emit(enc_r(0, 1, 1, 0, 2));
    emit(enc_r(0, 1, 2, 0, 3));
    emit(enc_r(0, 2, 3, 0, 4));
    emit(enc_r(0, 3, 4, 0, 5));
    store_reg(5, 32'd8);
    store_reg(4, 32'd5);
    // running sum in x6, the newer x6 sits in memory and the older one in writeback
    emit(enc_r(0, 5, 5, 0, 6));
    emit(enc_r(0, 1, 6, 0, 6));
    emit(enc_r(0, 1, 6, 0, 6));
    store_reg(6, 32'd18);
    emit(enc_j(0, 0));
    // load-use
    cur_row = 2;
    emit(enc_i(0, 0, 2, 1, OPC_LOAD));
    emit(enc_r(0, 1, 1, 0, 2));
    store_reg(2, rand_word(0) + rand_word(0));
    emit(enc_i(4, 0, 2, 3, OPC_LOAD));
    emit(enc_i(7, 3, 0, 4, OPC_OPI));
    store_reg(4, rand_word(1) + 32'd7);
    emit(enc_i(8, 0, 2, 5, OPC_LOAD));
    store_reg(5, rand_word(2));
    emit(enc_j(0, 0));
    // branches, x1 = -1 and x2 = 1
    cur_row = 3;
    emit(enc_i(-1, 0, 0, 1, OPC_OPI));
    emit(enc_i(1, 0, 0, 2, OPC_OPI));
    emit(enc_i(32'h33, 0, 0, 3, OPC_OPI));
    emit(enc_i(32'h44, 0, 0, 4, OPC_OPI));
    for (int c = 0; c < 6; c++) begin
      emit(enc_b(12, t_a[c], t_b[c], f3s[c]));
      emit_skipped();
      emit_skipped();
      store_reg(4, 32'h44);
      emit(enc_b(8, n_a[c], n_b[c], f3s[c]));
      store_reg(3, 32'h33);
    end
    emit(enc_j(0, 0));
    // x0 writes, jal to 0x14 and jalr to 0x2c
    cur_row = 4;
    emit(enc_i(5, 0, 0, 0, OPC_OPI));
    store_reg(0, 32'h0);
    emit(enc_j(12, 1));
    emit_skipped();
    emit_skipped();
    store_reg(1, 32'h0000_000c);
    emit(enc_i(44, 0, 0, 5, OPC_OPI));
    emit(enc_i(0, 5, 0, 6, OPC_JALR));
    emit_skipped();
    emit_skipped();
    emit_skipped();
    store_reg(6, 32'h0000_0020);
    emit(enc_j(0, 0));
  endtask

  // unused slots hold addi x0, x0 with the word index as immediate
  task automatic reset_and_load(input int row);
    @(posedge i_clk);
    #1;
    i_rst = 1'b1;
    for (int i = 0; i < 64; i++) begin
      imem[i] = (i < n_words[row]) ? prog[row][i] : enc_i(i, 0, 0, 0, OPC_OPI);
    end
    repeat (5) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
  endtask

  task automatic wait_store();
    int cycles;
    cycles = 0;
    @(negedge i_clk);
    while (o_dmem_we !== 1'b1) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("no store arrived before the timeout in row %0d", cur_row);
        abort_run();
      end
      @(negedge i_clk);
    end
  endtask

  initial begin
    i_rst        = 1'b1;
    i_imem_data  = '0;
    i_dmem_rdata = '0;
    for (int i = 0; i < 16; i++) begin
      dmem[i] = rand_word(i);
    end
    build_table();
    for (int row = 0; row < N_ROWS; row++) begin
      cur_row = row;
      reset_and_load(row);
      for (int k = 0; k < n_stores[row]; k++) begin
        wait_store();
        check_eq($sformatf("row %0d store %0d o_dmem_addr", row, k), o_dmem_addr,
                 exp_addr[row][k]);
        check_eq($sformatf("row %0d store %0d o_dmem_wdata", row, k), o_dmem_wdata,
                 exp_val[row][k]);
      end
      // program now spins on its last jump
      repeat (20) begin
        @(negedge i_clk);
        if (o_dmem_we === 1'b1) begin
          $display("an extra store appeared in row %0d after the expected list", row);
          abort_run();
        end
      end
    end
    $display("test passed");
    $finish;
  end

endmodule

// ==== pipelined.f ====
verilog/rv_pkg.sv
verilog/id_ex_if.sv
verilog/regfile.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/hazard_unit.sv
verilog/pipelined.sv
testbench/pipelined_chk.sv
testbench/tb_pipelined.sv

// ==== run.sh ====
#!/bin/sh
# compile and run with Verilator, the log decides pass or fail
mkdir -p build &&
verilator --binary --timing --assert --top-module tb_pipelined --Mdir build \
  -o vtb_pipelined -f pipelined.f > build/run.log 2>&1 &&
./build/vtb_pipelined >> build/run.log 2>&1
cat build/run.log
grep -q "test failed" build/run.log && exit 1
grep -q "test passed" build/run.log || exit 1
exit 0
